// ==== verilog.f ====
+incdir+source
source/shadow_pkg.sv
source/cfg_req_decode.sv
source/cfg_shadow_mem.sv
source/cfg_cpl_tx.sv
source/cfg_shadow_top.sv
tb/tb_cfg_shadow.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the configuration shadow testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cfg_shadow \
    -f verilog.f \
    -o tb_cfg_shadow
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_cfg_shadow
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

echo "simulation finished with status 0"
exit 0

// ==== tb/tb_cfg_shadow.sv ====
`timescale 1ns/1ns

`include "shadow_cfg.svh"

module tb_cfg_shadow;

    localparam int AW = `SHADOW_ADDR_W;
    localparam logic [6:0] FT_RD = 7'b0000010;
    localparam logic [6:0] FT_WR = 7'b0100010;
    localparam int MAX_OUTSTANDING = 12;
    localparam int WAIT_LIMIT = 2000;

    logic                  clk_pcie;
    logic                  rst;
    shadow_pkg::tlp_rx_t   tlp;
    logic [15:0]           pcie_id;
    logic                  cfg_en;
    logic                  cfg_wr_en;
    shadow_pkg::cpl_beat_t cpl;
    logic                  cpl_ready;

    // reference model state
    logic [31:0]  model_mem [`SHADOW_DEPTH];
    logic [127:0] exp_data [$];
    logic [3:0]   exp_keep [$];
    int           n_sent;
    int           n_recv;
    logic         bp_on;

    cfg_shadow_top DUT (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_tlp       (tlp),
        .i_pcie_id   (pcie_id),
        .i_cfg_en    (cfg_en),
        .i_cfg_wr_en (cfg_wr_en),
        .o_cpl       (cpl),
        .i_cpl_ready (cpl_ready)
    );

    always #10 clk_pcie = ~clk_pcie;

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    // --------------------------------------------------
    // model helpers
    // --------------------------------------------------
    function automatic logic is_ro(input logic [AW-1:0] addr);
        return (addr == AW'(`SHADOW_RO_DW0)) || (addr == AW'(`SHADOW_RO_DW1));
    endfunction

    // byte by byte update where identity dwords never move
    function automatic void model_write(input logic [AW-1:0] addr, input logic [3:0] be,
                                        input logic [31:0] wdata);
        if (!is_ro(addr)) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    model_mem[addr][8*k +: 8] = wdata[8*k +: 8];
                end
            end
        end
    endfunction

    function automatic logic [127:0] expect_cpl(input logic is_rd, input logic [7:0] tag,
                                                input logic [15:0] req_id,
                                                input logic [31:0] rdata);
        logic [31:0] dw0;
        logic [31:0] dw1;
        logic [31:0] dw2;
        logic [31:0] dw3;
        dw0 = is_rd ? 32'h4a00_0001 : 32'h0a00_0001;
        dw1 = {pcie_id[7:0], pcie_id[15:8], 16'h0004};
        dw2 = {req_id, tag, 8'h00};
        dw3 = is_rd ? rdata : 32'h0000_0000;
        return {dw3, dw2, dw1, dw0};
    endfunction

    // header fields over random filler
    function automatic logic [127:0] make_beat(input logic [6:0] ft, input logic [AW-1:0] addr,
                                               input logic [3:0] be, input logic [31:0] wdata,
                                               input logic [7:0] tag, input logic [15:0] req_id);
        logic [127:0] d;
        d = {$urandom(), $urandom(), $urandom(), $urandom()};
        d[31:25] = ft;
        for (int k = 0; k < 4; k++) begin
            d[35 - k] = be[k];
        end
        d[47:40] = tag;
        d[63:48] = req_id;
        d[75:66] = addr;
        d[127:96] = wdata;
        return d;
    endfunction

    function automatic logic [AW-1:0] pick_addr();
        logic [2:0] sel;
        sel = 3'($urandom());
        if (sel == 3'd0) begin
            return AW'(`SHADOW_RO_DW0);
        end else if (sel == 3'd1) begin
            return AW'(`SHADOW_RO_DW1);
        end else begin
            return AW'($urandom());
        end
    endfunction

    // --------------------------------------------------
    // output monitor with an in-order scoreboard
    // --------------------------------------------------
    always @(posedge clk_pcie) begin
        if (!rst && cpl.valid && cpl_ready) begin
            if (exp_data.size() == 0) begin
                $display("SOME TESTS FAILED");
                $fatal(1, "completion beat at %0t with none expected", $time);
            end else begin
                check_value("completion data", cpl.data, exp_data[0]);
                check_value("completion keep_dw", 128'(cpl.keep_dw), 128'(exp_keep[0]));
                check_value("completion last", 128'(cpl.last), 128'(1'b1));
                exp_data.delete(0);
                exp_keep.delete(0);
                n_recv++;
            end
        end
    end

    // step to the falling edge then clear the beat and refresh ready
    task automatic next_cycle();
        @(negedge clk_pcie);
        tlp = '0;
        if (bp_on) begin
            cpl_ready = 1'($urandom());
        end else begin
            cpl_ready = 1'b1;
        end
    endtask

    task automatic wait_room();
        int waited;
        waited = 0;
        while ((n_sent - n_recv) >= MAX_OUTSTANDING && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if ((n_sent - n_recv) >= MAX_OUTSTANDING) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timed out waiting for room in the completion queue");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (n_recv != n_sent && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (n_recv != n_sent) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timed out waiting for outstanding completions");
        end
        // idle gap so a stray beat would show up
        for (int i = 0; i < 6; i++) begin
            next_cycle();
        end
    endtask

    task automatic send_cfg(input logic is_wr, input logic [AW-1:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
        logic [7:0]  tag;
        logic [15:0] req_id;
        tag = 8'($urandom());
        req_id = 16'($urandom());
        wait_room();
        next_cycle();
        tlp.valid = 1'b1;
        tlp.sof = 1'b1;
        tlp.data = make_beat(is_wr ? FT_WR : FT_RD, addr, be, wdata, tag, req_id);
        if (cfg_en) begin
            if (is_wr) begin
                if (cfg_wr_en) begin
                    model_write(addr, be, wdata);
                end
                exp_data.push_back(expect_cpl(1'b0, tag, req_id, 32'h0));
                exp_keep.push_back(4'b0111);
            end else begin
                exp_data.push_back(expect_cpl(1'b1, tag, req_id, model_mem[addr]));
                exp_keep.push_back(4'b1111);
            end
            n_sent++;
        end
    endtask

    // other fmt/type or a config header without sof
    task automatic send_junk();
        logic [6:0] ft;
        logic       use_sof;
        use_sof = 1'($urandom());
        if (use_sof) begin
            ft = 7'($urandom());
            if (ft == FT_RD || ft == FT_WR) begin
                ft = ft ^ 7'b1000000;
            end
        end else begin
            ft = ($urandom() % 2 == 0) ? FT_RD : FT_WR;
        end
        next_cycle();
        tlp.valid = 1'b1;
        tlp.sof = use_sof;
        tlp.data = make_beat(ft, pick_addr(), 4'($urandom()), $urandom(), 8'($urandom()),
                             16'($urandom()));
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        logic [AW-1:0] addr;
        logic [AW-1:0] en_addrs [$];
        void'($urandom(26570));
        clk_pcie = 1'b0;
        rst = 1'b1;
        tlp = '0;
        pcie_id = 16'($urandom());
        cfg_en = 1'b1;
        cfg_wr_en = 1'b1;
        cpl_ready = 1'b1;
        bp_on = 1'b0;
        n_sent = 0;
        n_recv = 0;
        for (int i = 0; i < `SHADOW_DEPTH; i++) begin
            model_mem[AW'(i)] = 32'h0000_0000;
        end
        model_mem[AW'(`SHADOW_RO_DW0)] = {`SHADOW_DEVICE_ID, `SHADOW_VENDOR_ID};
        model_mem[AW'(`SHADOW_RO_DW1)] = `SHADOW_CLASS_REV;
        for (int i = 0; i < 8; i++) begin
            next_cycle();
        end
        rst = 1'b0;

        // identity dwords first and then random reads
        send_cfg(1'b0, AW'(`SHADOW_RO_DW0), 4'hf, 32'h0);
        send_cfg(1'b0, AW'(`SHADOW_RO_DW1), 4'hf, 32'h0);
        for (int i = 0; i < 40; i++) begin
            send_cfg(1'b0, pick_addr(), 4'hf, 32'h0);
        end
        drain();

        // masked writes each read back on the next beat
        for (int i = 0; i < 150; i++) begin
            addr = pick_addr();
            send_cfg(1'b1, addr, 4'($urandom()), $urandom());
            send_cfg(1'b0, addr, 4'hf, 32'h0);
        end
        drain();

        // --------------------------------------------------
        // enable inputs
        // --------------------------------------------------
        cfg_en = 1'b0;
        for (int i = 0; i < 20; i++) begin
            addr = pick_addr();
            en_addrs.push_back(addr);
            send_cfg(1'($urandom()), addr, 4'hf, $urandom());
        end
        drain();
        cfg_en = 1'b1;
        cfg_wr_en = 1'b0;
        for (int i = 0; i < 20; i++) begin
            addr = pick_addr();
            en_addrs.push_back(addr);
            send_cfg(1'b1, addr, 4'hf, $urandom());
        end
        drain();
        cfg_wr_en = 1'b1;
        foreach (en_addrs[i]) begin
            send_cfg(1'b0, en_addrs[i], 4'hf, 32'h0);
        end
        drain();

        // non-config beats mixed with real traffic
        for (int i = 0; i < 60; i++) begin
            send_junk();
            if ($urandom() % 3 == 0) begin
                send_cfg(1'($urandom()), pick_addr(), 4'($urandom()), $urandom());
            end
        end
        drain();

        // random stall on the completion side
        bp_on = 1'b1;
        for (int i = 0; i < 300; i++) begin
            send_cfg(1'($urandom()), pick_addr(), 4'($urandom()), $urandom());
        end
        drain();
        bp_on = 1'b0;
        drain();

        // single read into an empty queue shows valid after the third edge
        send_cfg(1'b0, pick_addr(), 4'hf, 32'h0);
        for (int i = 1; i <= 3; i++) begin
            next_cycle();
            check_value("latency valid", 128'(cpl.valid), 128'(i == 3));
        end
        drain();

        if (exp_data.size() == 0 && n_recv == n_sent) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "completion count mismatch at end of run");
        end
    end

endmodule

// ==== source/cfg_shadow_top.sv ====
`timescale 1ns/1ns

module cfg_shadow_top (
    input  logic                  clk_pcie,
    input  logic                  rst,
    input  shadow_pkg::tlp_rx_t   i_tlp,
    input  logic [15:0]           i_pcie_id,
    input  logic                  i_cfg_en,
    input  logic                  i_cfg_wr_en,
    output shadow_pkg::cpl_beat_t o_cpl,
    input  logic                  i_cpl_ready
);

    shadow_pkg::cfg_req_t req;
    shadow_pkg::cfg_rsp_t rsp;

    // --------------------------------------------------
    // receive decode
    // --------------------------------------------------
    cfg_req_decode u_decode (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .i_tlp    (i_tlp),
        .i_cfg_en (i_cfg_en),
        .o_req    (req)
    );

    // shadow register file
    cfg_shadow_mem u_mem (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_req       (req),
        .i_cfg_wr_en (i_cfg_wr_en),
        .o_rsp       (rsp)
    );

    // --------------------------------------------------
    // completion build and queue
    // --------------------------------------------------
    cfg_cpl_tx u_cpl_tx (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .i_rsp       (rsp),
        .i_pcie_id   (i_pcie_id),
        .o_cpl       (o_cpl),
        .i_cpl_ready (i_cpl_ready)
    );

endmodule

// ==== source/cfg_cpl_tx.sv ====
`timescale 1ns/1ns

`include "shadow_cfg.svh"

module cfg_cpl_tx (
    input  logic                  clk_pcie,
    input  logic                  rst,
    input  shadow_pkg::cfg_rsp_t  i_rsp,
    input  logic [15:0]           i_pcie_id,
    output shadow_pkg::cpl_beat_t o_cpl,
    input  logic                  i_cpl_ready
);

    localparam int CNT_W = `CPL_FIFO_AW + 1;
    localparam logic [CNT_W-1:0] FIFO_FULL_CNT = CNT_W'(`CPL_FIFO_DEPTH);

    // CplD carries one dw of data and Cpl carries none
    localparam logic [31:0] DW0_CPLD = 32'h4a00_0001;
    localparam logic [31:0] DW0_CPL  = 32'h0a00_0001;
    localparam logic [31:0] CPL_BYTE_CNT = 32'h0000_0004;

    logic        is_rd;
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;
    logic [31:0] dw3;
    logic [127:0] cpl_data;
    logic [3:0]   cpl_keep;

    logic [127:0] fifo_data [`CPL_FIFO_DEPTH];
    logic [3:0]   fifo_keep [`CPL_FIFO_DEPTH];

    logic [`CPL_FIFO_AW-1:0] wr_ptr;
    logic [`CPL_FIFO_AW-1:0] rd_ptr;
    logic [CNT_W-1:0]        fifo_cnt;
    logic                    fifo_full;
    logic                    fifo_empty;
    logic                    push;
    logic                    pop;

    // --------------------------------------------------
    // completion header and payload
    // --------------------------------------------------
    assign is_rd = (i_rsp.op == shadow_pkg::CFG_RD);

    assign dw0 = is_rd ? DW0_CPLD : DW0_CPL;
    // completer id goes out byte swapped
    assign dw1 = {i_pcie_id[7:0], i_pcie_id[15:8], CPL_BYTE_CNT[15:0]};
    assign dw2 = {i_rsp.req_id, i_rsp.tag, 8'h00};
    assign dw3 = is_rd ? i_rsp.rdata : 32'h0000_0000;

    assign cpl_data = {dw3, dw2, dw1, dw0};
    assign cpl_keep = is_rd ? 4'b1111 : 4'b0111;

    // --------------------------------------------------
    // first-word-fall-through queue
    // --------------------------------------------------
    assign fifo_full  = (fifo_cnt == FIFO_FULL_CNT);
    assign fifo_empty = (fifo_cnt == '0);

    // a completion arriving on a full queue is dropped
    assign push = i_rsp.valid && !fifo_full;
    assign pop  = !fifo_empty && i_cpl_ready;

    always_ff @(posedge clk_pcie) begin
        if (push) begin
            fifo_data[wr_ptr] <= cpl_data;
            fifo_keep[wr_ptr] <= cpl_keep;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: fifo_cnt <= fifo_cnt + 1'b1;
                2'b01: fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // head of queue drives the output
    assign o_cpl.valid   = !fifo_empty;
    assign o_cpl.data    = fifo_data[rd_ptr];
    assign o_cpl.keep_dw = fifo_keep[rd_ptr];
    assign o_cpl.last    = 1'b1;

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_cnt_in_range: assert property (
        @(posedge clk_pcie) disable iff (rst)
        fifo_cnt <= FIFO_FULL_CNT
    ) else $error("completion queue occupancy above depth");

    a_stall_stable: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (o_cpl.valid && !i_cpl_ready) |=> $stable(o_cpl)
    ) else $error("completion beat changed while stalled");

endmodule

// ==== source/cfg_shadow_mem.sv ====
`timescale 1ns/1ns

`include "shadow_cfg.svh"

module cfg_shadow_mem (
    input  logic                 clk_pcie,
    input  logic                 rst,
    input  shadow_pkg::cfg_req_t i_req,
    input  logic                 i_cfg_wr_en,
    output shadow_pkg::cfg_rsp_t o_rsp
);

    logic [31:0] mem [`SHADOW_DEPTH];

    logic        wr_hit;
    logic        rd_hit;
    logic [31:0] be_mask;
    logic [31:0] bit_mask;

    logic                rsp_valid;
    shadow_pkg::cfg_op_e rsp_op;
    logic [7:0]          rsp_tag;
    logic [15:0]         rsp_req_id;
    logic [31:0]         rsp_rdata;

    // identity dwords get an all-zero write mask
    function automatic logic [31:0] dword_wr_mask(input logic [`SHADOW_ADDR_W-1:0] addr);
        logic [31:0] mask;
        mask = 32'hffff_ffff;
        if (addr == `SHADOW_ADDR_W'(`SHADOW_RO_DW0) ||
            addr == `SHADOW_ADDR_W'(`SHADOW_RO_DW1)) begin
            mask = 32'h0000_0000;
        end
        return mask;
    endfunction

    // --------------------------------------------------
    // power-up contents
    // --------------------------------------------------
    initial begin
        for (int i = 0; i < `SHADOW_DEPTH; i++) begin
            mem[i] = 32'h0000_0000;
        end
        mem[`SHADOW_RO_DW0] = {`SHADOW_DEVICE_ID, `SHADOW_VENDOR_ID};
        mem[`SHADOW_RO_DW1] = `SHADOW_CLASS_REV;
    end

    assign wr_hit = i_req.valid && (i_req.op == shadow_pkg::CFG_WR) && i_cfg_wr_en;
    assign rd_hit = i_req.valid && (i_req.op == shadow_pkg::CFG_RD);

    // expand byte enables and combine with the fixed mask
    assign be_mask = {{8{i_req.be[3]}}, {8{i_req.be[2]}}, {8{i_req.be[1]}}, {8{i_req.be[0]}}};
    assign bit_mask = be_mask & dword_wr_mask(i_req.addr);

    // --------------------------------------------------
    // memory port writes and reads at the request edge
    // --------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (wr_hit) begin
            mem[i_req.addr] <= (mem[i_req.addr] & ~bit_mask) | (i_req.wdata & bit_mask);
        end
        if (rd_hit) begin
            rsp_rdata <= mem[i_req.addr];
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= i_req.valid;
        end
    end

    // request fields ride along for the completion
    always_ff @(posedge clk_pcie) begin
        if (i_req.valid) begin
            rsp_op     <= i_req.op;
            rsp_tag    <= i_req.tag;
            rsp_req_id <= i_req.req_id;
        end
    end

    assign o_rsp.valid  = rsp_valid;
    assign o_rsp.op     = rsp_op;
    assign o_rsp.tag    = rsp_tag;
    assign o_rsp.req_id = rsp_req_id;
    assign o_rsp.rdata  = rsp_rdata;

    // every request yields exactly one response one cycle later
    a_rsp_follows_req: assert property (
        @(posedge clk_pcie) disable iff (rst)
        o_rsp.valid == $past(i_req.valid)
    ) else $error("response does not follow request by one cycle");

endmodule

// ==== source/cfg_req_decode.sv ====
`timescale 1ns/1ns

module cfg_req_decode (
    input  logic                 clk_pcie,
    input  logic                 rst,
    input  shadow_pkg::tlp_rx_t  i_tlp,
    input  logic                 i_cfg_en,
    output shadow_pkg::cfg_req_t o_req
);

    // fmt[2:0] and type[4:1] of CfgRd0/CfgWr0
    localparam logic [6:0] FT_CFG_RD = 7'b0000010;
    localparam logic [6:0] FT_CFG_WR = 7'b0100010;

    logic                is_cand;
    logic                is_rd;
    logic                is_wr;
    logic                accept;
    shadow_pkg::cfg_op_e op_next;
    logic [3:0]          be_next;

    logic                req_valid;
    shadow_pkg::cfg_op_e req_op;
    logic [9:0]          req_addr;
    logic [3:0]          req_be;
    logic [31:0]         req_wdata;
    logic [7:0]          req_tag;
    logic [15:0]         req_id;

    // --------------------------------------------------
    // classify the start-of-packet beat
    // --------------------------------------------------
    assign is_cand = i_tlp.valid && i_tlp.sof;
    assign is_rd   = (i_tlp.data[31:25] == FT_CFG_RD);
    assign is_wr   = (i_tlp.data[31:25] == FT_CFG_WR);
    assign accept  = is_cand && (is_rd || is_wr) && i_cfg_en;
    assign op_next = is_wr ? shadow_pkg::CFG_WR : shadow_pkg::CFG_RD;

    // first dw byte enables sit reversed in bits 35:32
    assign be_next = {i_tlp.data[32], i_tlp.data[33], i_tlp.data[34], i_tlp.data[35]};

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    // payload only loads on an accepted beat
    always_ff @(posedge clk_pcie) begin
        if (accept) begin
            req_op    <= op_next;
            req_addr  <= i_tlp.data[75:66];
            req_be    <= be_next;
            req_wdata <= i_tlp.data[127:96];
            req_tag   <= i_tlp.data[47:40];
            req_id    <= i_tlp.data[63:48];
        end
    end

    assign o_req.valid  = req_valid;
    assign o_req.op     = req_op;
    assign o_req.addr   = req_addr;
    assign o_req.be     = req_be;
    assign o_req.wdata  = req_wdata;
    assign o_req.tag    = req_tag;
    assign o_req.req_id = req_id;

    // a request only ever comes from a sof beat one cycle earlier
    a_req_from_sof: assert property (
        @(posedge clk_pcie) disable iff (rst)
        o_req.valid |-> $past(i_tlp.valid && i_tlp.sof)
    ) else $error("request without a start-of-packet beat");

endmodule

// ==== source/shadow_pkg.sv ====
`include "shadow_cfg.svh"

package shadow_pkg;

    // --------------------------------------------------
    // configuration request opcodes
    // --------------------------------------------------
    typedef enum logic {
        CFG_RD = 1'b0,
        CFG_WR = 1'b1
    } cfg_op_e;

    // one 128-bit receive beat
    typedef struct packed {
        logic         valid;
        logic         sof;
        logic [127:0] data;
    } tlp_rx_t;

    // decoded request as a one cycle strobe
    typedef struct packed {
        logic                      valid;
        cfg_op_e                   op;
        logic [`SHADOW_ADDR_W-1:0] addr;
        logic [3:0]                be;
        logic [31:0]               wdata;
        logic [7:0]                tag;
        logic [15:0]               req_id;
    } cfg_req_t;

    // result from the shadow memory
    typedef struct packed {
        logic        valid;
        cfg_op_e     op;
        logic [7:0]  tag;
        logic [15:0] req_id;
        logic [31:0] rdata;
    } cfg_rsp_t;

    // --------------------------------------------------
    // outgoing completion beat
    // --------------------------------------------------
    typedef struct packed {
        logic         valid;
        logic [127:0] data;
        logic [3:0]   keep_dw;
        logic         last;
    } cpl_beat_t;

endpackage

// ==== source/shadow_cfg.svh ====
`ifndef SHADOW_CFG_SVH
`define SHADOW_CFG_SVH

// --------------------------------------------------
// shadow register file geometry
// --------------------------------------------------
`define SHADOW_ADDR_W 10
`define SHADOW_DEPTH 1024

// identity values loaded at power-up
`define SHADOW_VENDOR_ID 16'h1e5a
`define SHADOW_DEVICE_ID 16'h7a31
`define SHADOW_CLASS_REV 32'h0580_0001

// read-only dwords have an all-zero write mask
`define SHADOW_RO_DW0 0
`define SHADOW_RO_DW1 2

// --------------------------------------------------
// completion queue
// --------------------------------------------------
`define CPL_FIFO_DEPTH 16
`define CPL_FIFO_AW 4

`endif
